/* eth_mac_tx.f */
source/eth_pkg.sv
source/eth_tx_if.sv
source/eth_regs.sv
source/eth_frame_buf.sv
source/eth_tx.sv
source/eth_mac_tx.sv
testbench/tb_eth_mac_tx.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --timescale 1ns/1ns \
   --top-module tb_eth_mac_tx \
   -f eth_mac_tx.f \
   --Mdir obj_dir \
   -o sim_eth_mac_tx

./obj_dir/sim_eth_mac_tx

/* testbench/tb_eth_mac_tx.sv */
`timescale 1ns/1ns

module tb_eth_mac_tx;
   import eth_pkg::*;

   localparam int          CLK_PERIOD      = 4;
   localparam logic [31:0] SEED            = 32'hcaad_7274;
   localparam int          NBYTES_RESET    = 46;
   localparam int          SCRATCH_WORDS   = 8;
   localparam int          NUM_RAND_FRAMES = 8;
   localparam int          MAX_LEN         = 100;
   localparam int          ABORT_LEN       = 60;
   // Budget per frame covers the line time, the gap and the host traffic
   localparam int FRAME_MAX  = 16 + 2 * MAX_LEN + 8;
   localparam int APB_MAX    = 3 * (MAX_LEN + 6);
   localparam int PER_FRAME  = 2 * (FRAME_MAX + IFG_CYCLES + APB_MAX);
   localparam int RUN_CYCLES = 4 * PHY_RST_CYCLES + 6 * SCRATCH_WORDS
                               + (NUM_RAND_FRAMES + 2) * PER_FRAME + 100;
   localparam int MAX_POLLS  = (FRAME_MAX + IFG_CYCLES + PHY_RST_CYCLES) / 3 + 8;

   logic    clk = 1'b0;
   logic    rst_int, psel, penable, pwrite;
   addr_t   paddr;
   word_t   pwdata, prdata;
   logic    phy_resetn, tx_en;
   nibble_t tx_data;

   string   test_name;
   byte_t   payload [0:MAX_LEN-1];
   nibble_t got_q [$];
   nibble_t exp_q [$];
   int      exp_len [$];
   int      frames_sent = 0;
   int      frames_seen = 0;
   int      cycle = 0;
   logic    tx_en_q = 1'b0;
   logic    abort_pending = 1'b0;

   eth_mac_tx u_eth_mac_tx (
      .clk (clk), .rst_int (rst_int), .psel (psel), .penable (penable), .pwrite (pwrite),
      .paddr (paddr), .pwdata (pwdata), .prdata (prdata), .phy_resetn (phy_resetn),
      .tx_en (tx_en), .tx_data (tx_data)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at first error");
   endtask

   task automatic compare_word(input string what, input word_t exp_w, input word_t act_w);
      assert (act_w == exp_w) else stop_on_error($sformatf(
         "mismatch %s %s: expected %h, actual %h", test_name, what, exp_w, act_w));
   endtask

   // Bytewise reflected CRC-32 returned complemented
   function automatic crc_t ref_crc(input int n);
      crc_t c;
      int   i;
      int   b;
      c = 32'hFFFF_FFFF;
      for (i = 0; i < n; i++) begin
         c = c ^ {24'b0, payload[i]};
         for (b = 0; b < 8; b++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
         end
      end
      return ~c;
   endfunction

   // Reference nibble stream of one frame
   function automatic void expect_frame(input int n);
      crc_t fcs;
      int   i;
      fcs = ref_crc(n);
      for (i = 0; i < PREAMBLE_NIBBLES; i++) begin
         exp_q.push_back(4'h5);
      end
      exp_q.push_back(4'hD);
      for (i = 0; i < n; i++) begin
         exp_q.push_back(payload[i][3:0]);
         exp_q.push_back(payload[i][7:4]);
      end
      for (i = 0; i < 8; i++) begin
         exp_q.push_back(fcs[4*i +: 4]);
      end
      exp_len.push_back(PREAMBLE_NIBBLES + 1 + 2 * n + 8);
   endfunction

   task automatic check_frame();
      int      n_exp;
      int      i;
      nibble_t exp_nib;
      assert (exp_len.size() != 0) else stop_on_error($sformatf(
         "%s: frame appeared on the MII with no SEND pending", test_name));
      n_exp = exp_len.pop_front();
      if (abort_pending) begin
         assert (got_q.size() < n_exp) else stop_on_error($sformatf(
            "%s: frame was not cut short by the soft reset", test_name));
         for (i = 0; i < n_exp; i++) begin
            exp_nib = exp_q.pop_front();
         end
         abort_pending = 1'b0;
      end else begin
         assert (got_q.size() == n_exp) else stop_on_error($sformatf(
            "%s: frame had %0d nibbles but %0d were due", test_name, got_q.size(), n_exp));
         for (i = 0; i < n_exp; i++) begin
            exp_nib = exp_q.pop_front();
            assert (got_q[i] == exp_nib) else stop_on_error($sformatf(
               "mismatch %s nibble %0d: expected %h, actual %h", test_name, i, exp_nib,
               got_q[i]));
         end
      end
      got_q.delete();
      frames_seen++;
   endtask

   // One burst of tx_en is one frame
   always @(negedge clk) begin
      if (tx_en) begin
         got_q.push_back(tx_data);
      end else if (tx_en_q) begin
         check_frame();
      end
      tx_en_q = tx_en;
   end

   task automatic apb_write(input addr_t addr, input word_t data);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk);
      penable = 1'b1;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input addr_t addr, output word_t data);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge clk);
      penable = 1'b1;
      #1 data = prdata;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic wait_ready();
      word_t st;
      int    polls;
      polls = 0;
      apb_read(ADDR_STATUS, st);
      while (!st[0] && polls < MAX_POLLS) begin
         apb_read(ADDR_STATUS, st);
         polls++;
      end
      assert (st[0]) else stop_on_error($sformatf(
         "%s: ready did not return after %0d STATUS reads", test_name, polls));
   endtask

   task automatic send_frame(input int n, input logic write_len);
      int i;
      for (i = 0; i < n; i++) begin
         payload[i] = byte_t'($urandom);
         apb_write({1'b1, buf_addr_t'(i)}, {24'b0, payload[i]});
      end
      if (write_len) begin
         apb_write(ADDR_TX_NBYTES, word_t'(n));
      end
      expect_frame(n);
      frames_sent++;
      apb_write(ADDR_SEND, 32'h1);
   endtask

   initial begin
      word_t rd;
      word_t wr;
      int    t0;
      int    f;
      void'($urandom(SEED));
      rst_int = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      test_name = "reset";
      repeat (2) @(negedge clk);
      rst_int = 1'b0;
      t0 = cycle;
      assert (!tx_en && !phy_resetn) else stop_on_error("tx_en or phy_resetn high after reset");
      apb_read(ADDR_STATUS, rd);
      compare_word("STATUS", 32'h0, rd);
      apb_read(ADDR_TX_NBYTES, rd);
      compare_word("TX_NBYTES", NBYTES_RESET, rd);
      wait_ready();
      assert (cycle - t0 >= PHY_RST_CYCLES) else stop_on_error("ready before PHY reset ended");
      apb_read(ADDR_STATUS, rd);
      compare_word("STATUS", 32'h3, rd);

      test_name = "scratch";
      for (f = 0; f < SCRATCH_WORDS; f++) begin
         wr = $urandom;
         apb_write(ADDR_SCRATCH, wr);
         apb_read(ADDR_SCRATCH, rd);
         compare_word("SCRATCH", wr, rd);
      end

      test_name = "default_frame";
      send_frame(NBYTES_RESET, 1'b0);
      wait_ready();
      assert (frames_seen == frames_sent) else stop_on_error("default frame was not seen");

      test_name = "random_frames";
      for (f = 0; f < NUM_RAND_FRAMES; f++) begin
         wait_ready();
         send_frame(1 + int'($urandom % MAX_LEN), 1'b1);
         apb_read(ADDR_STATUS, rd);
         assert (!rd[0]) else stop_on_error("STATUS bit 0 high while a frame is sent");
         // Busy engine must drop this one
         apb_write(ADDR_SEND, 32'h1);
      end
      wait_ready();
      assert (frames_seen == frames_sent) else stop_on_error("random frames missing on the MII");

      test_name = "soft_reset";
      apb_write(ADDR_SCRATCH, $urandom | 32'h1);
      send_frame(ABORT_LEN, 1'b1);
      repeat (4) @(negedge clk);
      assert (tx_en) else stop_on_error("frame did not start after SEND");
      abort_pending = 1'b1;
      apb_write(ADDR_SOFTRST, 32'h1);
      t0 = cycle;
      assert (!tx_en) else stop_on_error("tx_en still high after soft reset");
      apb_read(ADDR_STATUS, rd);
      compare_word("STATUS", 32'h0, rd);
      apb_read(ADDR_TX_NBYTES, rd);
      compare_word("TX_NBYTES", NBYTES_RESET, rd);
      apb_read(ADDR_SCRATCH, rd);
      compare_word("SCRATCH", 32'h0, rd);
      wait_ready();
      assert (cycle - t0 >= PHY_RST_CYCLES) else stop_on_error("ready before PHY reset ended");
      assert (frames_seen == frames_sent) else stop_on_error("aborted frame was not seen");

      $display("NO ERRORS");
      $finish;
   end

   initial begin
      #(RUN_CYCLES * CLK_PERIOD);
      $display("ERRORS FOUND");
      $fatal(1, "run timed out after %0d cycles", RUN_CYCLES);
   end

endmodule

/* source/eth_mac_tx.sv */
`timescale 1ns/1ns

module eth_mac_tx (
   input  logic             clk,
   input  logic             rst_int,
   input  logic             psel,
   input  logic             penable,
   input  logic             pwrite,
   input  eth_pkg::addr_t   paddr,
   input  eth_pkg::word_t   pwdata,
   output eth_pkg::word_t   prdata,
   output logic             phy_resetn,
   output logic             tx_en,
   output eth_pkg::nibble_t tx_data
);
   import eth_pkg::*;

   logic      rst_core;
   logic      wr_en;
   buf_addr_t wr_addr;
   byte_t     wr_data;

   eth_tx_if tx_if ();

   // Host registers produce the frame
   eth_regs u_eth_regs (
      .clk        (clk),
      .rst_int    (rst_int),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .phy_resetn (phy_resetn),
      .rst_core   (rst_core),
      .wr_en      (wr_en),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data),
      .tx         (tx_if.ctrl)
   );

   eth_frame_buf u_eth_frame_buf (
      .clk     (clk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (tx_if.rd_addr),
      .rd_data (tx_if.rd_data)
   );

   eth_tx u_eth_tx (
      .clk      (clk),
      .rst_core (rst_core),
      .tx       (tx_if.engine),
      .tx_en    (tx_en),
      .tx_data  (tx_data)
   );

endmodule

/* source/eth_tx.sv */
`timescale 1ns/1ns

module eth_tx (
   input  logic             clk,
   input  logic             rst_core,
   eth_tx_if.engine         tx,
   output logic             tx_en,
   output eth_pkg::nibble_t tx_data
);
   import eth_pkg::*;

   tx_state_t  state;
   logic [4:0] cnt;
   nbytes_t    nbytes_q;
   nbytes_t    byte_cnt;
   byte_t      byte_q;
   logic       hi_nibble;
   logic       load_byte;
   crc_t       crc;
   buf_addr_t  rd_addr;

   // Four bits of reflected CRC per nibble
   function automatic crc_t crc_nibble(crc_t crc_in, nibble_t d);
      crc_t c;
      int   i;
      c = crc_in ^ {28'b0, d};
      for (i = 0; i < 4; i++) begin
         if (c[0]) begin
            c = (c >> 1) ^ CRC_POLY;
         end else begin
            c = c >> 1;
         end
      end
      return c;
   endfunction

   assign tx.ready   = (state == IDLE);
   assign tx.rd_addr = rd_addr;

   // Next byte is taken when its low nibble goes out
   assign load_byte = (state == SFD) ||
                      (state == PAYLOAD && !hi_nibble && byte_cnt != nbytes_q);

   always_ff @(posedge clk) begin
      if (load_byte) begin
         byte_q <= tx.rd_data;
      end
   end

   always_ff @(posedge clk or posedge rst_core) begin
      if (rst_core) begin
         state     <= IDLE;
         cnt       <= '0;
         nbytes_q  <= '0;
         byte_cnt  <= '0;
         hi_nibble <= 1'b0;
         crc       <= CRC_INIT;
         rd_addr   <= '0;
         tx_en     <= 1'b0;
         tx_data   <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (tx.send) begin
                  state     <= PREAMBLE;
                  cnt       <= 5'd1;
                  nbytes_q  <= tx.nbytes;
                  byte_cnt  <= '0;
                  hi_nibble <= 1'b0;
                  crc       <= CRC_INIT;
                  rd_addr   <= '0;
                  tx_en     <= 1'b1;
                  tx_data   <= PREAMBLE_NIBBLE;
               end
            end
            PREAMBLE: begin
               if (cnt == 5'(PREAMBLE_NIBBLES)) begin
                  state   <= SFD;
                  tx_data <= SFD_NIBBLE;
               end else begin
                  cnt     <= cnt + 5'd1;
                  tx_data <= PREAMBLE_NIBBLE;
               end
            end
            SFD, PAYLOAD: begin
               if (load_byte) begin
                  state     <= PAYLOAD;
                  tx_data   <= tx.rd_data[3:0];
                  crc       <= crc_nibble(crc, tx.rd_data[3:0]);
                  hi_nibble <= 1'b1;
                  byte_cnt  <= byte_cnt + 1'b1;
                  // Fetch ahead while the high nibble is sent
                  rd_addr   <= rd_addr + 1'b1;
               end else if (hi_nibble) begin
                  tx_data   <= byte_q[7:4];
                  crc       <= crc_nibble(crc, byte_q[7:4]);
                  hi_nibble <= 1'b0;
               end else begin
                  state   <= CRC;
                  cnt     <= 5'd1;
                  tx_data <= ~crc[3:0];
                  crc     <= crc >> 4;
               end
            end
            CRC: begin
               if (cnt == 5'(CRC_NIBBLES)) begin
                  state   <= GAP;
                  cnt     <= 5'd1;
                  tx_en   <= 1'b0;
                  tx_data <= '0;
               end else begin
                  cnt     <= cnt + 5'd1;
                  tx_data <= ~crc[3:0];
                  crc     <= crc >> 4;
               end
            end
            GAP: begin
               if (cnt == 5'(IFG_CYCLES)) begin
                  state <= IDLE;
               end else begin
                  cnt <= cnt + 5'd1;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   a_quiet_line: assert property (@(posedge clk) disable iff (rst_core)
      (state == IDLE || state == GAP) |-> !tx_en);

   a_send_when_idle: assert property (@(posedge clk) disable iff (rst_core)
      tx.send |-> state == IDLE);

endmodule

/* source/eth_frame_buf.sv */
`timescale 1ns/1ns

module eth_frame_buf (
   input  logic               clk,
   input  logic               wr_en,
   input  eth_pkg::buf_addr_t wr_addr,
   input  eth_pkg::byte_t     wr_data,
   input  eth_pkg::buf_addr_t rd_addr,
   output eth_pkg::byte_t     rd_data
);
   import eth_pkg::*;

   // One frame worth of payload
   byte_t mem [0:BUF_BYTES-1];

   // Host side write
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // Engine side read, one cycle latency
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

/* source/eth_regs.sv */
`timescale 1ns/1ns

module eth_regs (
   input  logic              clk,
   input  logic              rst_int,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  eth_pkg::addr_t    paddr,
   input  eth_pkg::word_t    pwdata,
   output eth_pkg::word_t    prdata,
   output logic              phy_resetn,
   output logic              rst_core,
   output logic              wr_en,
   output eth_pkg::buf_addr_t wr_addr,
   output eth_pkg::byte_t    wr_data,
   eth_tx_if.ctrl            tx
);
   import eth_pkg::*;

   logic    wr_access;
   logic    rd_access;
   logic    host_ready;
   logic    scratch_en;
   logic    nbytes_en;
   logic    send_en;
   logic    softrst_en;
   logic    rst_soft;
   logic    send;
   word_t   scratch;
   nbytes_t tx_nbytes;
   logic [$clog2(PHY_RST_CYCLES)-1:0] phy_cnt;

   assign rst_core   = rst_int | rst_soft;
   assign wr_access  = psel & penable & pwrite;
   assign rd_access  = psel & penable & ~pwrite;
   assign host_ready = tx.ready & phy_resetn;

   assign tx.send   = send;
   assign tx.nbytes = tx_nbytes;

   // Data window goes straight to the buffer
   assign wr_addr = paddr[10:0];
   assign wr_data = pwdata[7:0];

   // Write decode
   always_comb begin
      scratch_en = 1'b0;
      nbytes_en  = 1'b0;
      send_en    = 1'b0;
      softrst_en = 1'b0;
      wr_en      = 1'b0;
      if (wr_access) begin
         if (paddr[11]) begin
            wr_en = 1'b1;
         end else begin
            case (paddr)
               ADDR_SCRATCH:   scratch_en = 1'b1;
               ADDR_TX_NBYTES: nbytes_en  = 1'b1;
               // Dropped when the engine is busy
               ADDR_SEND:      send_en    = host_ready;
               ADDR_SOFTRST:   softrst_en = 1'b1;
               default:        ;
            endcase
         end
      end
   end

   // Read mux is zero outside the access phase
   always_comb begin
      prdata = '0;
      if (rd_access) begin
         case (paddr)
            ADDR_STATUS:    prdata = {30'b0, phy_resetn, host_ready};
            ADDR_SCRATCH:   prdata = scratch;
            ADDR_TX_NBYTES: prdata = {21'b0, tx_nbytes};
            default:        prdata = '0;
         endcase
      end
   end

   // Soft reset lasts one cycle
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         rst_soft <= 1'b0;
      end else begin
         rst_soft <= softrst_en & ~rst_soft;
      end
   end

   always_ff @(posedge clk or posedge rst_core) begin
      if (rst_core) begin
         send <= 1'b0;
      end else begin
         send <= send_en;
      end
   end

   always_ff @(posedge clk or posedge rst_core) begin
      if (rst_core) begin
         scratch   <= SCRATCH_DEFAULT;
         tx_nbytes <= NBYTES_DEFAULT;
      end else begin
         if (scratch_en) begin
            scratch <= pwdata;
         end
         if (nbytes_en) begin
            tx_nbytes <= pwdata[10:0];
         end
      end
   end

   // PHY held in reset for a fixed period
   always_ff @(posedge clk or posedge rst_core) begin
      if (rst_core) begin
         phy_cnt    <= '0;
         phy_resetn <= 1'b0;
      end else if (!phy_resetn) begin
         if (phy_cnt == PHY_RST_CYCLES - 1) begin
            phy_resetn <= 1'b1;
         end else begin
            phy_cnt <= phy_cnt + 1'b1;
         end
      end
   end

   a_send_pulse: assert property (@(posedge clk) disable iff (rst_core)
      tx.send |=> !tx.send);

endmodule

/* source/eth_tx_if.sv */
`timescale 1ns/1ns

interface eth_tx_if;
   import eth_pkg::*;

   // Control from the register block
   logic      send;
   nbytes_t   nbytes;
   logic      ready;

   // Frame buffer read port, driven by the engine
   buf_addr_t rd_addr;
   byte_t     rd_data;

   modport ctrl (
      output send,
      output nbytes,
      input  ready
   );

   modport engine (
      input  send,
      input  nbytes,
      input  rd_data,
      output ready,
      output rd_addr
   );

endinterface

/* source/eth_pkg.sv */
package eth_pkg;

   // Widths with a meaning of their own
   typedef logic [11:0] addr_t;
   typedef logic [31:0] word_t;
   typedef logic [7:0]  byte_t;
   typedef logic [3:0]  nibble_t;
   typedef logic [10:0] buf_addr_t;
   typedef logic [10:0] nbytes_t;
   typedef logic [31:0] crc_t;

   // Register map, data window at paddr[11]
   localparam addr_t ADDR_STATUS    = 12'h000;
   localparam addr_t ADDR_SCRATCH   = 12'h004;
   localparam addr_t ADDR_TX_NBYTES = 12'h008;
   localparam addr_t ADDR_SEND      = 12'h00C;
   localparam addr_t ADDR_SOFTRST   = 12'h010;

   // Reset values
   localparam nbytes_t NBYTES_DEFAULT  = 11'd46;
   localparam word_t   SCRATCH_DEFAULT = 32'h0000_0000;

   localparam int BUF_BYTES = 2048;

   // Short PHY reset for simulation
   localparam int PHY_RST_CYCLES = 64;

   // Frame layout on the MII side
   localparam int      PREAMBLE_NIBBLES = 15;
   localparam int      CRC_NIBBLES      = 8;
   localparam int      IFG_CYCLES       = 24;
   localparam nibble_t PREAMBLE_NIBBLE  = 4'h5;
   localparam nibble_t SFD_NIBBLE       = 4'hD;

   // Reflected Ethernet CRC-32
   localparam crc_t CRC_POLY = 32'hEDB8_8320;
   localparam crc_t CRC_INIT = 32'hFFFF_FFFF;

   typedef enum logic [2:0] {
      IDLE,
      PREAMBLE,
      SFD,
      PAYLOAD,
      CRC,
      GAP
   } tx_state_t;

endpackage
